//--- filelist.f
+incdir+testbench
logic/apb_subsys_pkg.sv
logic/ahb_endian_swap.sv
logic/ahb_to_apb_bridge.sv
logic/apb_slot_decode.sv
logic/gpio_apb.sv
logic/apb_subsystem.sv
testbench/tb_apb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench once per byte order
set -e
cd "$(dirname "$0")"
for be in 0 1
do
  verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_apb_subsystem -GBIG_ENDIAN=$be \
    --Mdir "obj_be$be" -f filelist.f
  out=$("./obj_be$be/Vtb_apb_subsystem" 2>&1 || true)
  printf '%s\n' "$out"
  if ! printf '%s\n' "$out" | grep -q "^TEST RESULT: PASS$"
  then
    echo "Simulation with BIG_ENDIAN=$be failed"
    exit 1
  fi
done
echo "Both configurations passed"

//--- testbench/tb_ahb_tasks.svh
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

  // ------------------------------------------------------------------------
  // Endian rule and AHB master tasks
  // ------------------------------------------------------------------------
  // Lane order seen on the AHB side for a little-endian register value
  // Byte size untouched, half swaps bytes in halves, word reverses all bytes
  function automatic logic [DATA_W-1:0] endian_map(input hsize_e size,
                                                   input logic [DATA_W-1:0] data);
    logic [7:0]        b [4];
    logic [DATA_W-1:0] res;
    for (int i = 0; i < 4; i++)
      b[i] = data[8*i +: 8];
    if (!BIG_ENDIAN || (size == BYTE))
      res = data;
    else if (size == HALF)
      res = {b[2], b[3], b[0], b[1]};
    else
      res = {b[0], b[1], b[2], b[3]};
    return res;
  endfunction

  // One single transfer, address phase then data phase
  task automatic ahb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input hsize_e size, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic resp,
                              output int low_cycles, output logic resp_while_low);
    @(posedge HCLK);
    #DRIVE_DELAY;
    i_hsel   = 1'b1;
    i_haddr  = addr;
    i_htrans = NONSEQ;
    i_hwrite = write;
    i_hsize  = size;
    // Accepting edge, bus goes idle for the data phase
    @(posedge HCLK);
    #DRIVE_DELAY;
    i_hsel   = 1'b0;
    i_htrans = IDLE;
    if (write)
      i_hwdata = wdata;
    low_cycles     = 0;
    resp_while_low = 1'b0;
    // Sampled mid-cycle, away from both edges
    @(negedge HCLK);
    while (!o_hreadyout)
    begin
      low_cycles++;
      resp_while_low = o_hresp;
      if (low_cycles >= READY_TIMEOUT)
        report_timeout(addr);
      @(negedge HCLK);
    end
    rdata = o_hrdata;
    resp  = o_hresp;
  endtask

`endif

//--- testbench/tb_apb_subsystem.sv
module tb_apb_subsystem
  import apb_subsys_pkg::*;
#(
  parameter bit BIG_ENDIAN = 1'b0
)
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int                DRIVE_DELAY   = 2;
  localparam int                READY_TIMEOUT = 20;
  localparam logic [DATA_W-1:0] ID0           = 32'hFA50C0;
  localparam logic [DATA_W-1:0] ID1           = 32'hFA50C1;

  logic              HCLK;
  logic              HRESETn;
  logic              i_hsel;
  logic [ADDR_W-1:0] i_haddr;
  htrans_e           i_htrans;
  logic              i_hwrite;
  hsize_e            i_hsize;
  logic              i_hready;
  logic [DATA_W-1:0] i_hwdata;
  logic              o_hreadyout;
  logic [DATA_W-1:0] o_hrdata;
  logic              o_hresp;
  logic              o_apbactive;
  logic [DATA_W-1:0] o_gpio0;
  logic [DATA_W-1:0] o_gpio1;

  integer            seed;
  logic [DATA_W-1:0] word;
  // Model of both GPIO output registers
  logic [DATA_W-1:0] exp_gpio [2];

  apb_subsystem #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_apb_subsystem (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hsize     (i_hsize),
    .i_hready    (i_hready),
    .i_hwdata    (i_hwdata),
    .o_hreadyout (o_hreadyout),
    .o_hrdata    (o_hrdata),
    .o_hresp     (o_hresp),
    .o_apbactive (o_apbactive),
    .o_gpio0     (o_gpio0),
    .o_gpio1     (o_gpio1)
  );

  // 40 ns period
  always #20 HCLK = ~HCLK;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first failed check");
  endtask

  task automatic report_timeout(input logic [ADDR_W-1:0] addr);
    $display("Ready wait timed out at %0t ns, transfer to %h never completed", $time, addr);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped on a ready timeout");
  endtask

  `include "tb_ahb_tasks.svh"

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] slot, input gpio_reg_e r);
    return {slot, r};
  endfunction

  // ------------------------------------------------------------------------
  // Checked accesses
  // ------------------------------------------------------------------------
  // OKAY word write, two wait cycles for a zero-wait slave
  task automatic write_ok(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rdata;
    logic              resp;
    logic              resp_low;
    int                low;
    ahb_transfer(1'b1, addr, WORD, data, rdata, resp, low, resp_low);
    assert (!resp && (low == 2))
      else report_mismatch($sformatf("write %h: resp %b after %0d waits", addr, resp, low));
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr, input hsize_e size,
                            input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] rdata;
    logic              resp;
    logic              resp_low;
    int                low;
    ahb_transfer(1'b0, addr, size, '0, rdata, resp, low, resp_low);
    assert (!resp && (low == 2) && (rdata == exp))
      else report_mismatch($sformatf("read %h: got %h resp %b waits %0d, expected %h",
                                     addr, rdata, resp, low, exp));
  endtask

  // Error write, hresp must already be high in the last wait cycle
  task automatic write_err(input logic [ADDR_W-1:0] addr, input hsize_e size,
                           input logic [DATA_W-1:0] data, input int exp_low);
    logic [DATA_W-1:0] rdata;
    logic              resp;
    logic              resp_low;
    int                low;
    ahb_transfer(1'b1, addr, size, data, rdata, resp, low, resp_low);
    assert (resp && resp_low && (low == exp_low))
      else report_mismatch($sformatf("write %h: no two-cycle error, waits %0d", addr, low));
  endtask

  task automatic check_gpio();
    assert ((o_gpio0 == exp_gpio[0]) && (o_gpio1 == exp_gpio[1]))
      else report_mismatch($sformatf("gpio %h/%h, expected %h/%h",
                                     o_gpio0, o_gpio1, exp_gpio[0], exp_gpio[1]));
  endtask

  // ------------------------------------------------------------------------
  // Bus protocol checks
  // ------------------------------------------------------------------------
  a_active_in_wait : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !o_hreadyout |-> o_apbactive
  ) else report_mismatch("o_apbactive low during a wait state");

  // Error opens with a wait state
  a_err_first : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $rose(o_hresp) |-> !o_hreadyout
  ) else report_mismatch("error response started with o_hreadyout high");

  a_err_second : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $past(o_hresp) && !$past(o_hreadyout) |-> o_hresp && o_hreadyout
  ) else report_mismatch("second cycle of the error response missing");

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial
  begin
    HCLK     = 1'b0;
    HRESETn  = 1'b0;
    i_hsel   = 1'b0;
    i_haddr  = '0;
    i_htrans = IDLE;
    i_hwrite = 1'b0;
    i_hsize  = WORD;
    i_hready = 1'b1;
    i_hwdata = '0;
    seed     = 32'h2adf;
    exp_gpio[0] = '0;
    exp_gpio[1] = '0;
    repeat (3) @(posedge HCLK);
    #DRIVE_DELAY;
    HRESETn = 1'b1;
    @(negedge HCLK);
    assert (o_hreadyout && !o_hresp && !o_apbactive)
      else report_mismatch("bus outputs not idle after reset");
    check_gpio();

    // Data register, written and read back in both slots
    for (int s = 0; s < 2; s++)
    begin
      word = $random(seed);
      write_ok(reg_addr(4'(s), REG_DATA), word);
      exp_gpio[s] = endian_map(WORD, word);
      check_gpio();
      read_check(reg_addr(4'(s), REG_DATA), WORD, endian_map(WORD, exp_gpio[s]));
    end

    // Set and clear registers, both read as zero
    for (int s = 0; s < 2; s++)
    begin
      repeat (2)
      begin
        word = $random(seed);
        write_ok(reg_addr(4'(s), REG_SET), word);
        exp_gpio[s] = exp_gpio[s] | endian_map(WORD, word);
        check_gpio();
        word = $random(seed);
        write_ok(reg_addr(4'(s), REG_CLR), word);
        exp_gpio[s] = exp_gpio[s] & ~endian_map(WORD, word);
        check_gpio();
      end
      read_check(reg_addr(4'(s), REG_SET), WORD, '0);
      read_check(reg_addr(4'(s), REG_CLR), WORD, '0);
    end

    // ID is read only, a write gets the slave error
    for (int s = 0; s < 2; s++)
    begin
      read_check(reg_addr(4'(s), REG_ID), WORD, endian_map(WORD, (s == 0) ? ID0 : ID1));
      write_err(reg_addr(4'(s), REG_ID), WORD, $random(seed), 3);
      check_gpio();
      read_check(reg_addr(4'(s), REG_ID), WORD, endian_map(WORD, (s == 0) ? ID0 : ID1));
    end

    // Empty slot, rejected byte write, narrow reads
    read_check(16'h5000, WORD, '0);
    write_err(reg_addr(4'd0, REG_DATA), BYTE, $random(seed), 1);
    check_gpio();
    read_check(reg_addr(4'd0, REG_DATA), BYTE, endian_map(BYTE, exp_gpio[0]));
    read_check(reg_addr(4'd0, REG_DATA), HALF, endian_map(HALF, exp_gpio[0]));

    repeat (2) @(posedge HCLK);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- logic/apb_subsystem.sv
module apb_subsystem
  import apb_subsys_pkg::*;
#(
  parameter bit                    BIG_ENDIAN  = 1'b0,
  parameter logic [SLOT_COUNT-1:0] SLOT_ENABLE = 16'h0003
)
(
  input  logic              HCLK,
  input  logic              HRESETn,
  // AHB-Lite slave port
  input  logic              i_hsel,
  input  logic [ADDR_W-1:0] i_haddr,
  input  htrans_e           i_htrans,
  input  logic              i_hwrite,
  input  hsize_e            i_hsize,
  input  logic              i_hready,
  input  logic [DATA_W-1:0] i_hwdata,
  output logic              o_hreadyout,
  output logic [DATA_W-1:0] o_hrdata,
  output logic              o_hresp,
  output logic              o_apbactive,
  // GPIO pins
  output logic [DATA_W-1:0] o_gpio0,
  output logic [DATA_W-1:0] o_gpio1
);

  logic                        accept;
  logic     [DATA_W-1:0]       wdata_le;
  logic     [DATA_W-1:0]       rdata_le;
  apb_req_t                    apb_req;
  logic                        apb_psel;
  logic     [SLOT_COUNT-1:0]   slot_sel;
  apb_rsp_t [SLOT_COUNT-1:0]   slot_rsp;
  apb_rsp_t                    apb_rsp;

  // ------------------------------------------------------------------------
  // AHB side
  // ------------------------------------------------------------------------
  ahb_endian_swap #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_endian_swap (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .i_accept   (accept),
    .i_hsize    (i_hsize),
    .i_hwdata   (i_hwdata),
    .i_rdata_le (rdata_le),
    .o_wdata_le (wdata_le),
    .o_hrdata   (o_hrdata)
  );

  ahb_to_apb_bridge u_bridge (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hsize     (i_hsize),
    .i_hready    (i_hready),
    .i_wdata_le  (wdata_le),
    .i_rsp       (apb_rsp),
    .o_accept    (accept),
    .o_hreadyout (o_hreadyout),
    .o_hresp     (o_hresp),
    .o_rdata_le  (rdata_le),
    .o_req       (apb_req),
    .o_psel      (apb_psel),
    .o_apbactive (o_apbactive)
  );

  // ------------------------------------------------------------------------
  // APB side
  // ------------------------------------------------------------------------
  apb_slot_decode #(
    .SLOT_ENABLE (SLOT_ENABLE)
  ) u_slot_decode (
    .i_psel      (apb_psel),
    .i_req       (apb_req),
    .i_slot_rsp  (slot_rsp),
    .o_slot_sel  (slot_sel),
    .o_rsp       (apb_rsp)
  );

  // Slot 0
  gpio_apb #(
    .GPIO_ID (32'hFA50C0)
  ) u_gpio0 (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .i_psel  (slot_sel[0]),
    .i_req   (apb_req),
    .o_rsp   (slot_rsp[0]),
    .o_gpio  (o_gpio0)
  );

  // Slot 1
  gpio_apb #(
    .GPIO_ID (32'hFA50C1)
  ) u_gpio1 (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .i_psel  (slot_sel[1]),
    .i_req   (apb_req),
    .o_rsp   (slot_rsp[1]),
    .o_gpio  (o_gpio1)
  );

  // Slots 2 to 15 are empty
  for (genvar s = 2; s < SLOT_COUNT; s++)
  begin : g_empty_slot
    assign slot_rsp[s] = APB_RSP_DEFAULT;
  end

endmodule

//--- logic/gpio_apb.sv
module gpio_apb
  import apb_subsys_pkg::*;
#(
  parameter logic [DATA_W-1:0] GPIO_ID = '0
)
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              i_psel,
  input  apb_req_t          i_req,
  output apb_rsp_t          o_rsp,
  output logic [DATA_W-1:0] o_gpio
);

  logic [DATA_W-1:0] gpio_q;
  gpio_reg_e         reg_sel;
  logic              wr_access;

  // Offset within the slot
  assign reg_sel = gpio_reg_e'(i_req.paddr[SLOT_LSB-1:0]);

  // Writes take effect in the access phase
  assign wr_access = i_psel && i_req.penable && i_req.pwrite;

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      gpio_q <= '0;
    else if (wr_access)
    begin
      case (reg_sel)
        REG_DATA: gpio_q <= i_req.pwdata;
        // Set and clear only touch bits written as one
        REG_SET:  gpio_q <= gpio_q | i_req.pwdata;
        REG_CLR:  gpio_q <= gpio_q & ~i_req.pwdata;
        default:  gpio_q <= gpio_q;
      endcase
    end
  end

  assign o_gpio = gpio_q;

  // ------------------------------------------------------------------------
  // Read data and response
  // ------------------------------------------------------------------------
  always_comb
  begin
    case (reg_sel)
      REG_DATA: o_rsp.prdata = gpio_q;
      REG_ID:   o_rsp.prdata = GPIO_ID;
      // SET, CLR and holes read zero
      default:  o_rsp.prdata = '0;
    endcase
  end

  // Zero wait states
  assign o_rsp.pready  = 1'b1;
  // ID is read only
  assign o_rsp.pslverr = wr_access && (reg_sel == REG_ID);

endmodule

//--- logic/apb_slot_decode.sv
module apb_slot_decode
  import apb_subsys_pkg::*;
#(
  parameter logic [SLOT_COUNT-1:0] SLOT_ENABLE = 16'h0003
)
(
  input  logic                            i_psel,
  input  apb_req_t                        i_req,
  input  apb_rsp_t [SLOT_COUNT-1:0]       i_slot_rsp,
  output logic     [SLOT_COUNT-1:0]       o_slot_sel,
  output apb_rsp_t                        o_rsp
);

  localparam int SLOT_W = $clog2(SLOT_COUNT);

  logic [SLOT_W-1:0] slot_idx;
  logic              slot_hit;

  // ------------------------------------------------------------------------
  // Select generation
  // ------------------------------------------------------------------------
  // Slot number from the top address nibble
  assign slot_idx = i_req.paddr[SLOT_LSB +: SLOT_W];

  // Disabled slots never see a select
  assign slot_hit = SLOT_ENABLE[slot_idx];

  always_comb
  begin
    o_slot_sel = '0;
    if (i_psel && slot_hit)
      o_slot_sel[slot_idx] = 1'b1;
  end

  // ------------------------------------------------------------------------
  // Response mux
  // ------------------------------------------------------------------------
  // Empty slot completes at once with zero data
  always_comb
  begin
    if (slot_hit)
      o_rsp = i_slot_rsp[slot_idx];
    else
      o_rsp = APB_RSP_DEFAULT;
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // At most one select, and only towards a populated slot
  always_comb
  begin
    a_sel_onehot : assert ($onehot0(o_slot_sel) && ((o_slot_sel & ~SLOT_ENABLE) == '0))
      else $error("slot select not one-hot or hits a disabled slot");
  end

endmodule

//--- logic/ahb_to_apb_bridge.sv
module ahb_to_apb_bridge
  import apb_subsys_pkg::*;
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              i_hsel,
  input  logic [ADDR_W-1:0] i_haddr,
  input  htrans_e           i_htrans,
  input  logic              i_hwrite,
  input  hsize_e            i_hsize,
  input  logic              i_hready,
  input  logic [DATA_W-1:0] i_wdata_le,
  input  apb_rsp_t          i_rsp,
  output logic              o_accept,
  output logic              o_hreadyout,
  output logic              o_hresp,
  output logic [DATA_W-1:0] o_rdata_le,
  output apb_req_t          o_req,
  output logic              o_psel,
  output logic              o_apbactive
);

  bridge_state_e     state;
  bridge_state_e     state_nxt;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic [DATA_W-1:0] rdata_q;
  logic              bad_write;
  logic              access_done;

  // ------------------------------------------------------------------------
  // AHB address phase
  // ------------------------------------------------------------------------
  // Valid transfer on NONSEQ or SEQ only
  assign o_accept = i_hsel && i_hready && ((i_htrans == NONSEQ) || (i_htrans == SEQ));

  // APB has no strobes, so only word writes are allowed
  assign bad_write = i_hwrite && (i_hsize != WORD);

  assign access_done = (state == ST_ACCESS) && i_rsp.pready;

  // Address and direction held for the APB transfer
  always_ff @(posedge HCLK)
  begin
    if (o_accept)
    begin
      addr_q  <= i_haddr;
      write_q <= i_hwrite;
    end
  end

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      // Ready states, a new address phase may be accepted here
      ST_IDLE, ST_RDONE, ST_ERR2:
      begin
        if (o_accept)
          state_nxt = bad_write ? ST_ERR1 : ST_SETUP;
        else
          state_nxt = ST_IDLE;
      end
      ST_SETUP:
        state_nxt = ST_ACCESS;
      // Wait states until the slave is ready
      ST_ACCESS:
      begin
        if (i_rsp.pready)
          state_nxt = i_rsp.pslverr ? ST_ERR1 : ST_RDONE;
      end
      ST_ERR1:
        state_nxt = ST_ERR2;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // Read data captured at the end of the access phase
  always_ff @(posedge HCLK)
  begin
    if (access_done && !write_q)
      rdata_q <= i_rsp.prdata;
  end

  // ------------------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------------------
  assign o_psel      = (state == ST_SETUP) || (state == ST_ACCESS);
  // Low through setup, access and the first error cycle
  assign o_hreadyout = !(o_psel || (state == ST_ERR1));
  assign o_hresp     = (state == ST_ERR1) || (state == ST_ERR2);
  assign o_apbactive = (state != ST_IDLE);
  assign o_rdata_le  = rdata_q;

  // Write data comes straight from the held AHB data phase
  assign o_req.paddr   = addr_q;
  assign o_req.pwrite  = write_q;
  assign o_req.pwdata  = i_wdata_le;
  assign o_req.penable = (state == ST_ACCESS);

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // Access phase always preceded by a setup cycle
  a_penable_after_setup : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $rose(o_req.penable) |-> $past(o_psel) && o_psel
  ) else $error("penable without preceding setup phase");

  // Request held from setup until the end of access
  a_req_stable : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    o_psel && $past(o_psel) |->
      $stable(o_req.paddr) && $stable(o_req.pwrite) &&
      (!o_req.pwrite || $stable(o_req.pwdata))
  ) else $error("APB request changed during transfer");

  // Rejected write never reaches the APB side
  a_bad_write_no_apb : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    o_accept && bad_write |=> !o_psel ##1 !o_psel
  ) else $error("non-word write started an APB transfer");

endmodule

//--- logic/ahb_endian_swap.sv
module ahb_endian_swap
  import apb_subsys_pkg::*;
#(
  parameter bit BIG_ENDIAN = 1'b0
)
(
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              i_accept,
  input  hsize_e            i_hsize,
  input  logic [DATA_W-1:0] i_hwdata,
  input  logic [DATA_W-1:0] i_rdata_le,
  output logic [DATA_W-1:0] o_wdata_le,
  output logic [DATA_W-1:0] o_hrdata
);

  swap_ctrl_t swap_ctrl;
  swap_ctrl_t swap_nxt;

  // Byte swap for half and word, halfword swap for word only
  always_comb
  begin
    swap_nxt.byte_swap = BIG_ENDIAN && ((i_hsize == HALF) || (i_hsize == WORD));
    swap_nxt.half_swap = BIG_ENDIAN && (i_hsize == WORD);
  end

  // Held through the whole data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      swap_ctrl <= '0;
    else if (i_accept)
      swap_ctrl <= swap_nxt;
  end

  // Bytes within each halfword first, then the two halfwords
  function automatic logic [DATA_W-1:0] swap_lanes(input swap_ctrl_t ctrl,
                                                   input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] stage;
    stage = ctrl.byte_swap ? {data[23:16], data[31:24], data[7:0], data[15:8]} : data;
    return ctrl.half_swap ? {stage[15:0], stage[31:16]} : stage;
  endfunction

  // Same swap both ways, it is its own inverse
  assign o_wdata_le = swap_lanes(swap_ctrl, i_hwdata);
  assign o_hrdata   = swap_lanes(swap_ctrl, i_rdata_le);

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  // Little-endian build never swaps, even after a word transfer
  a_le_no_swap : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    (BIG_ENDIAN == 1'b0) && i_accept |=> (swap_ctrl == '0)
  ) else $error("swap control set in little-endian configuration");

endmodule

//--- logic/apb_subsys_pkg.sv
package apb_subsys_pkg;

  // ------------------------------------------------------------------------
  // Bus geometry
  // ------------------------------------------------------------------------
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  // Top nibble of the address picks the APB slot
  localparam int SLOT_LSB   = 12;
  localparam int SLOT_COUNT = 16;

  // ------------------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // Bridge FSM, ERR1/ERR2 form the two-cycle AHB error
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_RDONE,
    ST_ERR1,
    ST_ERR2
  } bridge_state_e;

  // GPIO register offsets within a slot
  typedef enum logic [11:0] {
    REG_DATA = 12'h000,
    REG_SET  = 12'h004,
    REG_CLR  = 12'h008,
    REG_ID   = 12'hFFC
  } gpio_reg_e;

  // ------------------------------------------------------------------------
  // APB bundles
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic              penable;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic half_swap;
    logic byte_swap;
  } swap_ctrl_t;

  // Response of an empty slot: zero data, ready, OKAY
  localparam apb_rsp_t APB_RSP_DEFAULT = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};

endpackage
